/* fifo_ctl_pkg.sv */
//----------------------------
// Sizes and flag levels shared by the FIFO controller
// Depth must stay a power of two for the pointer arithmetic
//----------------------------
`default_nettype none

package fifo_ctl_pkg;

	// Geometry
	localparam int unsigned fifo_depth = 16;
	localparam int unsigned addr_w     = $clog2(fifo_depth);
	localparam int unsigned ptr_w      = addr_w + 1;

	// Flag levels, per side
	localparam int unsigned push_ae_lvl = 2;
	localparam int unsigned push_af_lvl = 3;
	localparam int unsigned pop_ae_lvl  = 3;
	localparam int unsigned pop_af_lvl  = 3;
	localparam int unsigned half_lvl    = fifo_depth / 2;

	// Gray pointers and occupancy counts
	typedef logic [ptr_w-1:0] ptr_t;

	// Binary pointer, as a number or as wrap bit plus RAM address
	typedef union packed {
		ptr_t bin;
		struct packed {
			logic              wrap;
			logic [addr_w-1:0] addr;
		} fld;
	} ptr_bin_u;

	//----------------------------
	// Gray code conversion
	//----------------------------
	function automatic ptr_t bin2gray(input ptr_t b);
		return b ^ (b >> 1);
	endfunction

	function automatic ptr_t gray2bin(input ptr_t g);
		ptr_t b;
		b[ptr_w-1] = g[ptr_w-1];
		for (int i = ptr_w - 2; i >= 0; i--)
			b[i] = b[i+1] ^ g[i];
		return b;
	endfunction

endpackage

`default_nettype wire

/* fifo_ptr_ctl.sv */
//----------------------------
// Pointer control for one clock domain of the FIFO
// block must be a registered flag of the same domain
// error is a one-cycle strobe, it does not hold
//----------------------------
`default_nettype none

module fifo_ptr_ctl
(
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               req_n,
	input  wire                               block,
	output logic                              allow_n,
	output fifo_ctl_pkg::ptr_bin_u            ptr_next,
	output fifo_ctl_pkg::ptr_t                ptr_gray,
	output logic [fifo_ctl_pkg::addr_w-1:0]   addr,
	output logic                              error
);

	import fifo_ctl_pkg::*;

	logic accept;
	logic blocked;
	ptr_t ptr_bin;

	// Request is taken only when the flag allows it
	assign accept  = ~req_n & ~block;
	assign blocked = ~req_n & block;

	// Write enable on the push side, active low
	assign allow_n = ~accept;

	// Current pointer held in Gray code only
	assign ptr_bin = gray2bin(ptr_gray);

	assign ptr_next.bin = ptr_bin + ptr_t'(accept);

	//----------------------------
	// Pointer and address registers
	//----------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			ptr_gray <= '0;
			addr     <= '0;
		end
		else
		begin
			ptr_gray <= bin2gray(ptr_next.bin);
			// Wrap bit dropped for the RAM
			addr     <= ptr_next.fld.addr;
		end
	end

	//----------------------------
	// Error strobe
	//----------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			error <= 1'b0;
		end
		else
		begin
			error <= blocked;
		end
	end

endmodule

`default_nettype wire

/* fifo_gray_sync.sv */
//----------------------------
// Two-flop synchronizer for a Gray pointer
// Safe only while one bit at most changes per source cycle
//----------------------------
`default_nettype none

module fifo_gray_sync
(
	input  wire                      clk,
	input  wire                      rst_n,
	input  wire fifo_ctl_pkg::ptr_t  ptr_in,
	output fifo_ctl_pkg::ptr_t       ptr_out
);

	import fifo_ctl_pkg::*;

	// First stage may go metastable
	ptr_t meta;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			meta    <= '0;
			ptr_out <= '0;
		end
		else
		begin
			meta    <= ptr_in;
			ptr_out <= meta;
		end
	end

endmodule

`default_nettype wire

/* fifo_level_flags.sv */
//----------------------------
// Occupancy count and level flags for one side
// Remote pointer lags by two to three local cycles
// so flags err on the safe side until it arrives
//----------------------------
`default_nettype none

module fifo_level_flags
#(
	parameter int unsigned ae_lvl    = fifo_ctl_pkg::push_ae_lvl,
	parameter int unsigned af_lvl    = fifo_ctl_pkg::push_af_lvl,
	parameter bit          push_side = 1'b1
)
(
	input  wire                          clk,
	input  wire                          rst_n,
	input  wire fifo_ctl_pkg::ptr_bin_u  local_next,
	input  wire fifo_ctl_pkg::ptr_t      remote_gray,
	output fifo_ctl_pkg::ptr_t           cnt,
	output logic                         empty,
	output logic                         ae,
	output logic                         hf,
	output logic                         af,
	output logic                         full
);

	import fifo_ctl_pkg::*;

	// Thresholds in count width
	localparam ptr_t ae_thr   = ptr_t'(ae_lvl);
	localparam ptr_t hf_thr   = ptr_t'(half_lvl);
	localparam ptr_t af_thr   = ptr_t'(fifo_depth - af_lvl);
	localparam ptr_t full_thr = ptr_t'(fifo_depth);

	ptr_t remote_bin;
	ptr_t occ;

	assign remote_bin = gray2bin(remote_gray);

	// Push side writes ahead of the reader, pop side trails the writer
	assign occ = push_side ? (local_next.bin - remote_bin)
	                       : (remote_bin - local_next.bin);

	//----------------------------
	// Registered count and flags
	//----------------------------
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cnt   <= '0;
			empty <= 1'b1;
			ae    <= 1'b1;
			hf    <= 1'b0;
			af    <= 1'b0;
			full  <= 1'b0;
		end
		else
		begin
			cnt   <= occ;
			empty <= (occ == '0);
			ae    <= (occ <= ae_thr);
			hf    <= (occ >= hf_thr);
			af    <= (occ >= af_thr);
			// Wrap bits differ and addresses match
			full  <= (occ == full_thr);
		end
	end

endmodule

`default_nettype wire

/* fifo_ctl_top.sv */
//----------------------------
// Dual-clock FIFO controller for an external RAM
// RAM needs a synchronous write port and an async read port
// Reset is asynchronous and clears both domains together
//----------------------------
`default_nettype none

module fifo_ctl_top
(
	input  wire                              clk_push,
	input  wire                              clk_pop,
	input  wire                              rst_n,
	input  wire                              push_req_n,
	input  wire                              pop_req_n,
	output wire                              we_n,
	output wire                              push_empty,
	output wire                              push_ae,
	output wire                              push_hf,
	output wire                              push_af,
	output wire                              push_full,
	output wire                              push_error,
	output wire                              pop_empty,
	output wire                              pop_ae,
	output wire                              pop_hf,
	output wire                              pop_af,
	output wire                              pop_full,
	output wire                              pop_error,
	output wire [fifo_ctl_pkg::addr_w-1:0]   wr_addr,
	output wire [fifo_ctl_pkg::addr_w-1:0]   rd_addr,
	output wire fifo_ctl_pkg::ptr_t          wr_fifo_cnt_out,
	output wire fifo_ctl_pkg::ptr_t          rd_fifo_cnt_out
);

	import fifo_ctl_pkg::*;

	// Next binary pointers, local to each domain
	wire ptr_bin_u wr_next;
	wire ptr_bin_u rd_next;

	// Gray pointers and their synchronized copies
	wire ptr_t     wr_gray;
	wire ptr_t     rd_gray;
	wire ptr_t     wr_gray_sync;
	wire ptr_t     rd_gray_sync;

	//----------------------------
	// Push domain
	//----------------------------
	fifo_ptr_ctl u_push_ptr (
		.clk      (clk_push),
		.rst_n    (rst_n),
		.req_n    (push_req_n),
		.block    (push_full),
		.allow_n  (we_n),
		.ptr_next (wr_next),
		.ptr_gray (wr_gray),
		.addr     (wr_addr),
		.error    (push_error)
	);

	fifo_gray_sync u_rd_sync (
		.clk     (clk_push),
		.rst_n   (rst_n),
		.ptr_in  (rd_gray),
		.ptr_out (rd_gray_sync)
	);

	fifo_level_flags #(
		.ae_lvl    (push_ae_lvl),
		.af_lvl    (push_af_lvl),
		.push_side (1'b1)
	) u_push_flags (
		.clk         (clk_push),
		.rst_n       (rst_n),
		.local_next  (wr_next),
		.remote_gray (rd_gray_sync),
		.cnt         (wr_fifo_cnt_out),
		.empty       (push_empty),
		.ae          (push_ae),
		.hf          (push_hf),
		.af          (push_af),
		.full        (push_full)
	);

	//----------------------------
	// Pop domain
	//----------------------------
	// No enable needed on the async read port
	fifo_ptr_ctl u_pop_ptr (
		.clk      (clk_pop),
		.rst_n    (rst_n),
		.req_n    (pop_req_n),
		.block    (pop_empty),
		.allow_n  (),
		.ptr_next (rd_next),
		.ptr_gray (rd_gray),
		.addr     (rd_addr),
		.error    (pop_error)
	);

	fifo_gray_sync u_wr_sync (
		.clk     (clk_pop),
		.rst_n   (rst_n),
		.ptr_in  (wr_gray),
		.ptr_out (wr_gray_sync)
	);

	fifo_level_flags #(
		.ae_lvl    (pop_ae_lvl),
		.af_lvl    (pop_af_lvl),
		.push_side (1'b0)
	) u_pop_flags (
		.clk         (clk_pop),
		.rst_n       (rst_n),
		.local_next  (rd_next),
		.remote_gray (wr_gray_sync),
		.cnt         (rd_fifo_cnt_out),
		.empty       (pop_empty),
		.ae          (pop_ae),
		.hf          (pop_hf),
		.af          (pop_af),
		.full        (pop_full)
	);

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
//----------------------------
// Free-running testbench clock
// Starts low, first rising edge after half a period
//----------------------------
`default_nettype none

module tb_clk_gen
#(
	parameter int period = 40
)
(
	output bit clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#(period / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

/* tb_fifo_ctl.sv */
//----------------------------
// Testbench for the dual-clock FIFO controller, no RAM modeled
// Model counts of the other domain may lag by half a cycle,
// which the synchronizer latency always covers
//----------------------------
`default_nettype none

module tb_fifo_ctl;

	import fifo_ctl_pkg::*;

	// Phase lengths in clk_pop cycles
	localparam int reset_cycles = 2;
	localparam int gap_cycles   = 8;
	localparam int fill_cycles  = 60;
	localparam int drain_cycles = 60;
	localparam int mixed_cycles = 120;
	localparam int total_cycles = reset_cycles + 4 * gap_cycles + fill_cycles
	                            + drain_cycles + mixed_cycles;
	localparam int max_cycles   = 2 * total_cycles;

	localparam logic [31:0] seed = 32'he4f6_6a7d;

	localparam int mode_quiet = 0;
	localparam int mode_fill  = 1;
	localparam int mode_drain = 2;
	localparam int mode_mixed = 3;

	bit               clk_push;
	bit               clk_pop;
	logic             rst_n;
	logic             push_req_n;
	logic             pop_req_n;
	wire              we_n;
	wire              push_empty;
	wire              push_ae;
	wire              push_hf;
	wire              push_af;
	wire              push_full;
	wire              push_error;
	wire              pop_empty;
	wire              pop_ae;
	wire              pop_hf;
	wire              pop_af;
	wire              pop_full;
	wire              pop_error;
	wire [addr_w-1:0] wr_addr;
	wire [addr_w-1:0] rd_addr;
	wire ptr_t        wr_fifo_cnt_out;
	wire ptr_t        rd_fifo_cnt_out;

	// Occupancy model and request state
	int          mode;
	int          n_push;
	int          n_pop;
	bit          push_acc;
	bit          push_blk;
	bit          pop_acc;
	bit          pop_blk;
	logic [31:0] push_rng;
	logic [31:0] pop_rng;
	bit          saw_full;
	bit          saw_push_block;
	bit          saw_pop_block;
	int          pop_cycles_run;

	tb_clk_gen #(.period(28)) u_push_clk (.clk(clk_push));
	tb_clk_gen #(.period(40)) u_pop_clk  (.clk(clk_pop));

	fifo_ctl_top dut (
		.clk_push        (clk_push),
		.clk_pop         (clk_pop),
		.rst_n           (rst_n),
		.push_req_n      (push_req_n),
		.pop_req_n       (pop_req_n),
		.we_n            (we_n),
		.push_empty      (push_empty),
		.push_ae         (push_ae),
		.push_hf         (push_hf),
		.push_af         (push_af),
		.push_full       (push_full),
		.push_error      (push_error),
		.pop_empty       (pop_empty),
		.pop_ae          (pop_ae),
		.pop_hf          (pop_hf),
		.pop_af          (pop_af),
		.pop_full        (pop_full),
		.pop_error       (pop_error),
		.wr_addr         (wr_addr),
		.rd_addr         (rd_addr),
		.wr_fifo_cnt_out (wr_fifo_cnt_out),
		.rd_fifo_cnt_out (rd_fifo_cnt_out)
	);

	//----------------------------
	// Helpers
	//----------------------------
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Fill and drain phases favor one side 7 to 1
	function automatic logic wants_request(input int m, input logic [31:0] r, input bit push);
		case (m)
			mode_fill:  return push ? (r[31:29] != 3'd0) : (r[31:29] == 3'd0);
			mode_drain: return push ? (r[31:29] == 3'd0) : (r[31:29] != 3'd0);
			mode_mixed: return r[28];
			default:    return 1'b0;
		endcase
	endfunction

	// Expected {empty, ae, hf, af, full} for an occupancy
	function automatic logic [4:0] level_flags(input int occ, input int ae_l, input int af_l);
		logic [4:0] f;
		f[4] = (occ == 0);
		f[3] = (occ <= ae_l);
		f[2] = (occ >= int'(half_lvl));
		f[1] = (occ >= int'(fifo_depth) - af_l);
		f[0] = (occ == int'(fifo_depth));
		return f;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] exp);
		$display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, got, exp);
		$display("sim failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic report_problem(input string msg);
		$display("%s", msg);
		$display("sim failed");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_reset_values();
		assert ({push_empty, push_ae, pop_empty, pop_ae} == 4'hf)
			else report_mismatch("empty and ae flags",
				32'({push_empty, push_ae, pop_empty, pop_ae}), 32'hf);
		assert ({push_hf, push_af, push_full, push_error,
		         pop_hf, pop_af, pop_full, pop_error} == 8'h00)
			else report_mismatch("hf, af, full and error flags",
				32'({push_hf, push_af, push_full, push_error,
				     pop_hf, pop_af, pop_full, pop_error}), 32'h0);
		assert (wr_fifo_cnt_out == '0)
			else report_mismatch("wr_fifo_cnt_out", 32'(wr_fifo_cnt_out), 32'h0);
		assert (rd_fifo_cnt_out == '0)
			else report_mismatch("rd_fifo_cnt_out", 32'(rd_fifo_cnt_out), 32'h0);
		assert (wr_addr == '0 && rd_addr == '0)
			else report_mismatch("wr_addr and rd_addr", 32'({wr_addr, rd_addr}), 32'h0);
		assert (we_n == 1'b1)
			else report_mismatch("we_n", 32'(we_n), 32'h1);
	endtask

	// Both domains idle long enough for the pointers to cross
	task automatic check_settled();
		int         occ;
		logic [4:0] exp_push;
		logic [4:0] exp_pop;
		occ      = n_push - n_pop;
		exp_push = level_flags(occ, int'(push_ae_lvl), int'(push_af_lvl));
		exp_pop  = level_flags(occ, int'(pop_ae_lvl), int'(pop_af_lvl));
		assert (wr_fifo_cnt_out == ptr_w'(occ))
			else report_mismatch("wr_fifo_cnt_out", 32'(wr_fifo_cnt_out), 32'(occ));
		assert (rd_fifo_cnt_out == ptr_w'(occ))
			else report_mismatch("rd_fifo_cnt_out", 32'(rd_fifo_cnt_out), 32'(occ));
		assert ({push_empty, push_ae, push_hf, push_af, push_full} == exp_push)
			else report_mismatch("push flags {empty,ae,hf,af,full}",
				32'({push_empty, push_ae, push_hf, push_af, push_full}), 32'(exp_push));
		assert ({pop_empty, pop_ae, pop_hf, pop_af, pop_full} == exp_pop)
			else report_mismatch("pop flags {empty,ae,hf,af,full}",
				32'({pop_empty, pop_ae, pop_hf, pop_af, pop_full}), 32'(exp_pop));
	endtask

	task automatic run_phase(input int m, input int cycles);
		mode <= m;
		repeat (cycles) @(negedge clk_pop);
	endtask

	//----------------------------
	// Push side driver and checks
	//----------------------------
	always @(negedge clk_push)
	begin : push_drive
		int          next_push;
		int          occ;
		logic        req_n;
		logic        exp_we_n;
		logic [31:0] rnd;
		next_push = n_push + int'(push_acc);
		occ       = next_push - n_pop;
		exp_we_n  = ~(~push_req_n & ~push_full);
		assert (push_error == push_blk)
			else report_mismatch("push_error", 32'(push_error), 32'(push_blk));
		assert (wr_addr == addr_w'(next_push % fifo_depth))
			else report_mismatch("wr_addr", 32'(wr_addr), 32'(next_push % fifo_depth));
		assert (we_n == exp_we_n)
			else report_mismatch("we_n", 32'(we_n), 32'(exp_we_n));
		if (occ == int'(fifo_depth))
		begin
			saw_full <= 1'b1;
			assert (push_full)
				else report_mismatch("push_full", 32'(push_full), 32'h1);
		end
		assert (occ >= 0 && occ <= int'(fifo_depth))
			else report_problem("Push side model occupancy left the range 0 to fifo_depth");
		rnd   = xorshift(push_rng);
		req_n = ~wants_request(mode, rnd, 1'b1);
		push_rng   <= rnd;
		push_req_n <= req_n;
		push_acc   <= ~req_n & ~push_full;
		push_blk   <= ~req_n & push_full;
		n_push     <= next_push;
		if (~req_n & push_full)
			saw_push_block <= 1'b1;
	end

	//----------------------------
	// Pop side driver and checks
	//----------------------------
	always @(negedge clk_pop)
	begin : pop_drive
		int          next_pop;
		int          occ;
		logic        req_n;
		logic [31:0] rnd;
		next_pop = n_pop + int'(pop_acc);
		occ      = n_push - next_pop;
		assert (pop_error == pop_blk)
			else report_mismatch("pop_error", 32'(pop_error), 32'(pop_blk));
		assert (rd_addr == addr_w'(next_pop % fifo_depth))
			else report_mismatch("rd_addr", 32'(rd_addr), 32'(next_pop % fifo_depth));
		if (occ == 0)
		begin
			assert (pop_empty)
				else report_mismatch("pop_empty", 32'(pop_empty), 32'h1);
		end
		assert (occ >= 0 && occ <= int'(fifo_depth))
			else report_problem("Pop side model occupancy left the range 0 to fifo_depth");
		rnd   = xorshift(pop_rng);
		req_n = ~wants_request(mode, rnd, 1'b0);
		pop_rng   <= rnd;
		pop_req_n <= req_n;
		pop_acc   <= ~req_n & ~pop_empty;
		pop_blk   <= ~req_n & pop_empty;
		n_pop     <= next_pop;
		if (~req_n & pop_empty)
			saw_pop_block <= 1'b1;
	end

	// Run limit
	always @(posedge clk_pop)
	begin
		pop_cycles_run++;
		if (pop_cycles_run > max_cycles)
			report_problem("Timeout, the run went past its clk_pop cycle limit");
	end

	//----------------------------
	// Phase sequence
	//----------------------------
	initial
	begin
		rst_n          = 1'b0;
		push_req_n     = 1'b1;
		pop_req_n      = 1'b1;
		mode           = mode_quiet;
		n_push         = 0;
		n_pop          = 0;
		push_acc       = 1'b0;
		push_blk       = 1'b0;
		pop_acc        = 1'b0;
		pop_blk        = 1'b0;
		push_rng       = seed;
		pop_rng        = seed ^ 32'h9e37_79b9;
		saw_full       = 1'b0;
		saw_push_block = 1'b0;
		saw_pop_block  = 1'b0;
		pop_cycles_run = 0;

		repeat (reset_cycles) @(negedge clk_pop);
		check_reset_values();
		rst_n <= 1'b1;

		run_phase(mode_quiet, gap_cycles);
		check_settled();
		run_phase(mode_fill, fill_cycles);
		run_phase(mode_quiet, gap_cycles);
		check_settled();
		run_phase(mode_drain, drain_cycles);
		run_phase(mode_quiet, gap_cycles);
		check_settled();
		run_phase(mode_mixed, mixed_cycles);
		run_phase(mode_quiet, gap_cycles);
		check_settled();

		if (!(saw_full && saw_push_block && saw_pop_block))
			report_problem("Stimulus never filled the FIFO or never blocked a request");
		else
		begin
			$display("sim passed");
			$finish;
		end
	end

endmodule

`default_nettype wire

/* fifo_ctl.f */
fifo_ctl_pkg.sv
fifo_ptr_ctl.sv
fifo_gray_sync.sv
fifo_level_flags.sv
fifo_ctl_top.sv
tb_clk_gen.sv
tb_fifo_ctl.sv

/* Makefile */
# Verilator flow for the dual-clock FIFO controller

VERILATOR  ?= verilator
TOP        := tb_fifo_ctl
FILELIST   := fifo_ctl.f
OBJ_DIR    := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
SIM_FLAGS  := --binary --timing --assert --top-module $(TOP) --Mdir $(OBJ_DIR)

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)

# The log decides pass or fail
sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "sim passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
